// File: dv/clock_renderer_props.sv
`default_nettype none

`include "clock_defs.svh"

module clock_renderer_props (
        input logic                  clk,
        input logic                  reset,
        input logic                  scan_req,
        input logic                  plot_req,
        input clock_pkg::fb_op_e     plot_op,
        input logic [`FB_ADDR_W-1:0] plot_row,
        input logic [`FB_ADDR_W-1:0] plot_col,
        input logic [`FB_DIM-1:0]    mem_rdata,
        input logic                  frame_busy
);
        timeunit 1ns;
        timeprecision 1ps;

        // scanner owns the port, a stalled plotter keeps its command
        scan_wins: assert property (@(posedge clk) disable iff (reset)
                (scan_req && plot_req) |=> ($stable(plot_op) && $stable(plot_row)
                                            && $stable(plot_col)))
                else $error("plotter moved on while the scanner held the port");

        // plotter idle on the first cycle out of reset
        idle_after_reset: assert property (@(posedge clk) reset |=> !frame_busy)
                else $error("frame_busy high right after reset");

        // no requester means the read row is left alone
        nop_when_quiet: assert property (@(posedge clk) disable iff (reset)
                (!scan_req && !plot_req) |=> $stable(mem_rdata))
                else $error("framebuffer read without a request");

endmodule

bind clock_renderer clock_renderer_props u_props (
        .clk        (clk),
        .reset      (reset),
        .scan_req   (scan_req),
        .plot_req   (plot_req),
        .plot_op    (plot_op),
        .plot_row   (plot_row),
        .plot_col   (plot_col),
        .mem_rdata  (mem_rdata),
        .frame_busy (frame_busy)
);

`default_nettype wire

// File: dv/clock_renderer_tb.sv
`default_nettype none

`include "clock_defs.svh"

module clock_renderer_tb;
        timeunit 1ns;
        timeprecision 1ps;

        logic                clk;
        logic                reset;
        logic                slow_clk;
        logic [3:0]          hour;
        logic [5:0]          minute;
        logic [5:0]          second;
        logic [3:0]          al_hour;
        logic [5:0]          al_minute;
        logic [`COORD_W-1:0] horiz_count;
        logic [`COORD_W-1:0] vert_count;
        logic [`COORD_W-1:0] x_offset;
        logic [`COORD_W-1:0] y_offset;
        logic                pixel_bw;
        logic                frame_busy;

        // expected image, bit index = column
        logic [`FB_DIM-1:0]  exp_img [0:`FB_DIM-1];
        // round(127 sin d), d = 0..90
        int                  sin_tbl [0:90];

        clock_renderer DUT (.*);

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        function automatic void build_table();
                real v;
                for (int d = 0; d <= 90; d++) begin
                        v = 127.0 * $sin(d * 3.14159265358979 / 180.0);
                        sin_tbl[d] = $rtoi($floor(v + 0.5));
                end
        endfunction

        // cos x taken as sin(x + 90), then the usual quadrant symmetry
        function automatic int trig(input int deg, input bit want_cos);
                int a;
                int q;
                int mag;
                a = want_cos ? (deg + 90) % 360 : deg % 360;
                q = a / 90;
                mag = (q % 2 == 0) ? sin_tbl[a % 90] : sin_tbl[90 - a % 90];
                return (q >= 2) ? -mag : mag;
        endfunction

        function automatic void clear_model();
                for (int k = 0; k < `FB_DIM; k++)
                        exp_img[k] = '0;
        endfunction

        // hands as dots at odd radii, offsets truncated toward zero
        function automatic void build_model(input int h, input int m, input int s,
                                            input int ah, input int am);
                int ang [4];
                int len [4];
                int row;
                int col;
                ang = '{(h * 60 + m) / 2, m * 6, s * 6, ah * 30 + (am / 10) * 6};
                len = '{`HOUR_LEN, `MIN_LEN, `SEC_LEN, `ALARM_LEN};
                clear_model();
                for (int k = 0; k < 4; k++) begin
                        for (int r = 1; r <= len[k]; r += 2) begin
                                row = `FB_CENTER - 1 - trig(ang[k], 1'b1) * r / `TRIG_MAX;
                                col = `FB_CENTER + trig(ang[k], 1'b0) * r / `TRIG_MAX;
                                exp_img[row][col] = 1'b1;
                        end
                end
        endfunction

        // x and y are screen coordinates
        task automatic check_pixel(input logic got, input logic expected,
                                   input int x, input int y);
                if (got !== expected) begin
                        $display("Error: pixel_bw at x %0d y %0d got %h expected %h",
                                 x, y, got, expected);
                        $display("CHECKS FAILED");
                        $fatal(1, "pixel mismatch");
                end
        endtask

        task automatic check_busy(input logic got, input logic expected);
                if (got !== expected) begin
                        $display("Error: frame_busy got %h expected %h", got, expected);
                        $display("CHECKS FAILED");
                        $fatal(1, "frame_busy mismatch");
                end
        endtask

        task automatic wait_busy(input logic level);
                int n;
                n = 0;
                while (frame_busy !== level) begin
                        @(negedge clk);
                        n++;
                        if (n > 1000) begin
                                $display("timeout while waiting for frame_busy to become %0d",
                                         level);
                                $display("CHECKS FAILED");
                                $fatal(1, "timeout");
                        end
                end
        endtask

        // pixel shows up two rising edges after the counters
        task automatic read_screen(input int hc, input int vc, output logic v);
                @(posedge clk);
                horiz_count <= 10'(hc);
                vert_count  <= 10'(vc);
                @(posedge clk);
                @(posedge clk);
                @(negedge clk);
                v = pixel_bw;
        endtask

        task automatic expect_fb(input int row, input int col, input logic expected);
                logic v;
                read_screen(col * `SCALE, row * `SCALE, v);
                check_pixel(v, expected, col * `SCALE, row * `SCALE);
        endtask

        task automatic compare_image();
                for (int r = 0; r < `FB_DIM; r++)
                        for (int c = 0; c < `FB_DIM; c++)
                                expect_fb(r, c, exp_img[r][c]);
        endtask

        // counters parked off screen so the plotter never stalls
        task automatic run_frame(input int h, input int m, input int s,
                                 input int ah, input int am);
                @(posedge clk);
                slow_clk    <= 1'b0;
                hour        <= 4'(h);
                minute      <= 6'(m);
                second      <= 6'(s);
                al_hour     <= 4'(ah);
                al_minute   <= 6'(am);
                horiz_count <= '1;
                vert_count  <= '1;
                @(posedge clk);
                slow_clk <= 1'b1;
                wait_busy(1'b1);
                wait_busy(1'b0);
                build_model(h, m, s, ah, am);
        endtask

        task automatic test_reset();
                @(negedge clk);
                check_busy(frame_busy, 1'b0);
                check_pixel(pixel_bw, 1'b0, 0, 0);
                clear_model();
                compare_image();
        endtask

        // every hand straight up
        task automatic test_noon();
                run_frame(0, 0, 0, 0, 0);
                for (int r = 1; r <= `MIN_LEN; r += 2) begin
                        expect_fb(31 - r, 32, 1'b1);
                        expect_fb(31 - r, 31, 1'b0);
                        expect_fb(31 - r, 33, 1'b0);
                end
                compare_image();
        endtask

        // hour 97, minute 90, second 270, alarm 180
        task automatic test_cardinal();
                run_frame(3, 15, 45, 6, 0);
                compare_image();
        endtask

        // hour 45, second 288
        task automatic test_diagonal();
                run_frame(1, 30, 48, 0, 0);
                compare_image();
        endtask

        task automatic test_redraw();
                // slow_clk still high from the last frame
                for (int i = 0; i < 150; i++) begin
                        @(negedge clk);
                        check_busy(frame_busy, 1'b0);
                end
                run_frame(2, 41, 17, 0, 0);
                compare_image();
        endtask

        task automatic test_scaling();
                int   xo;
                int   yo;
                int   row;
                int   col;
                int   hc;
                int   vc;
                logic v;
                row = 0;
                col = 0;
                for (int r = `FB_DIM - 1; r >= 0; r--)
                        for (int c = `FB_DIM - 1; c >= 0; c--)
                                if (exp_img[r][c]) begin
                                        row = r;
                                        col = c;
                                end
                xo = 1 + int'($urandom % 400);
                yo = 1 + int'($urandom % 400);
                @(posedge clk);
                x_offset <= 10'(xo);
                y_offset <= 10'(yo);
                for (int dy = 0; dy < `SCALE; dy++) begin
                        for (int dx = 0; dx < `SCALE; dx++) begin
                                hc = xo + col * `SCALE + dx;
                                vc = yo + row * `SCALE + dy;
                                read_screen(hc, vc, v);
                                check_pixel(v, 1'b1, hc, vc);
                        end
                end
                // one step past each window edge
                hc = xo + col * `SCALE;
                vc = yo + row * `SCALE;
                read_screen(xo - 1, vc, v);
                check_pixel(v, 1'b0, xo - 1, vc);
                read_screen(xo + `FB_DIM * `SCALE, vc, v);
                check_pixel(v, 1'b0, xo + `FB_DIM * `SCALE, vc);
                read_screen(hc, yo - 1, v);
                check_pixel(v, 1'b0, hc, yo - 1);
                read_screen(hc, yo + `FB_DIM * `SCALE, v);
                check_pixel(v, 1'b0, hc, yo + `FB_DIM * `SCALE);
                @(posedge clk);
                x_offset <= '0;
                y_offset <= '0;
        endtask

        initial begin
                void'($urandom(8280));
                reset       = 1'b1;
                slow_clk    = 1'b0;
                hour        = '0;
                minute      = '0;
                second      = '0;
                al_hour     = '0;
                al_minute   = '0;
                horiz_count = '1;
                vert_count  = '1;
                x_offset    = '0;
                y_offset    = '0;
                build_table();
                repeat (16) @(posedge clk);
                reset <= 1'b0;
                test_reset();
                test_noon();
                test_cardinal();
                test_diagonal();
                test_redraw();
                test_scaling();
                $display("ALL CHECKS PASSED");
                $finish;
        end

endmodule

`default_nettype wire

// File: logic/clock_defs.svh
`ifndef CLOCK_DEFS_SVH
`define CLOCK_DEFS_SVH

// framebuffer geometry, one bit per pixel
`define FB_DIM          64
`define FB_ADDR_W       6
`define FB_CENTER       32

// screen pixels per framebuffer pixel, both axes
`define SCALE           7
// width of the video counters and offsets
`define COORD_W         10

// angles in whole degrees, 0..359
`define ANGLE_W         9
// signed table values, full scale
`define TRIG_W          8
`define TRIG_MAX        127

// hand lengths in framebuffer pixels
`define HOUR_LEN        23
`define MIN_LEN         31
`define SEC_LEN         27
`define ALARM_LEN       17

`endif

// File: logic/clock_pkg.sv
`default_nettype none

package clock_pkg;

        // plotter frame sequence
        typedef enum logic [2:0] {
                IDLE,
                CLEAR,
                DRAW_HOUR,
                DRAW_MIN,
                DRAW_SEC,
                DRAW_ALARM
        } draw_state_e;

        // framebuffer port commands
        typedef enum logic [1:0] {
                FB_NOP,
                FB_CLEAR_ROW,
                FB_SET_PIXEL,
                FB_READ_ROW
        } fb_op_e;

endpackage

`default_nettype wire

// File: logic/clock_renderer.sv
`default_nettype none

`include "clock_defs.svh"

module clock_renderer (
        input  logic                 clk,
        input  logic                 reset,
        input  logic                 slow_clk,
        input  logic [3:0]           hour,
        input  logic [5:0]           minute,
        input  logic [5:0]           second,
        input  logic [3:0]           al_hour,
        input  logic [5:0]           al_minute,
        input  logic [`COORD_W-1:0]  horiz_count,
        input  logic [`COORD_W-1:0]  vert_count,
        input  logic [`COORD_W-1:0]  x_offset,
        input  logic [`COORD_W-1:0]  y_offset,
        output logic                 pixel_bw,
        output logic                 frame_busy
);

        // plotter side of the shared port
        logic                  plot_req;
        logic                  plot_gnt;
        clock_pkg::fb_op_e     plot_op;
        logic [`FB_ADDR_W-1:0] plot_row;
        logic [`FB_ADDR_W-1:0] plot_col;

        // scanner side
        logic                  scan_req;
        logic [`FB_ADDR_W-1:0] scan_row;

        // memory port after arbitration
        clock_pkg::fb_op_e     mem_op;
        logic [`FB_ADDR_W-1:0] mem_row;
        logic [`FB_ADDR_W-1:0] mem_col;
        logic [`FB_DIM-1:0]    mem_rdata;

        hand_plotter u_plotter (
                .clk        (clk),
                .reset      (reset),
                .slow_clk   (slow_clk),
                .hour       (hour),
                .minute     (minute),
                .second     (second),
                .al_hour    (al_hour),
                .al_minute  (al_minute),
                .plot_req   (plot_req),
                .plot_op    (plot_op),
                .plot_row   (plot_row),
                .plot_col   (plot_col),
                .plot_gnt   (plot_gnt),
                .frame_busy (frame_busy)
        );

        pixel_scanner u_scanner (
                .clk         (clk),
                .reset       (reset),
                .horiz_count (horiz_count),
                .vert_count  (vert_count),
                .x_offset    (x_offset),
                .y_offset    (y_offset),
                .scan_req    (scan_req),
                .scan_row    (scan_row),
                .mem_rdata   (mem_rdata),
                .pixel_bw    (pixel_bw)
        );

        framebuffer_arbiter u_arbiter (
                .scan_req (scan_req),
                .scan_row (scan_row),
                .plot_req (plot_req),
                .plot_op  (plot_op),
                .plot_row (plot_row),
                .plot_col (plot_col),
                .plot_gnt (plot_gnt),
                .mem_op   (mem_op),
                .mem_row  (mem_row),
                .mem_col  (mem_col)
        );

        framebuffer_ram u_ram (
                .clk       (clk),
                .reset     (reset),
                .mem_op    (mem_op),
                .mem_row   (mem_row),
                .mem_col   (mem_col),
                .mem_rdata (mem_rdata)
        );

endmodule

`default_nettype wire

// File: logic/framebuffer_arbiter.sv
`default_nettype none

`include "clock_defs.svh"

module framebuffer_arbiter (
        input  logic                   scan_req,
        input  logic [`FB_ADDR_W-1:0]  scan_row,
        input  logic                   plot_req,
        input  clock_pkg::fb_op_e      plot_op,
        input  logic [`FB_ADDR_W-1:0]  plot_row,
        input  logic [`FB_ADDR_W-1:0]  plot_col,
        output logic                   plot_gnt,
        output clock_pkg::fb_op_e      mem_op,
        output logic [`FB_ADDR_W-1:0]  mem_row,
        output logic [`FB_ADDR_W-1:0]  mem_col
);

        // scanner never stalls, plotter waits
        assign plot_gnt = plot_req && !scan_req;

        assign mem_row = scan_req ? scan_row : plot_row;
        // column only matters for a set
        assign mem_col = plot_col;

        always_comb begin
                if (scan_req)
                        mem_op = clock_pkg::FB_READ_ROW;
                else if (plot_req)
                        mem_op = plot_op;
                else
                        mem_op = clock_pkg::FB_NOP;
        end

endmodule

`default_nettype wire

// File: logic/framebuffer_ram.sv
`default_nettype none

`include "clock_defs.svh"

module framebuffer_ram (
        input  logic                   clk,
        input  logic                   reset,
        input  clock_pkg::fb_op_e      mem_op,
        input  logic [`FB_ADDR_W-1:0]  mem_row,
        input  logic [`FB_ADDR_W-1:0]  mem_col,
        output logic [`FB_DIM-1:0]     mem_rdata
);

        // one word per row, bit index = column
        logic [`FB_DIM-1:0] mem [0:`FB_DIM-1];

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        // blank screen out of reset
                        for (int i = 0; i < `FB_DIM; i++)
                                mem[i] <= '0;
                end else begin
                        case (mem_op)
                                clock_pkg::FB_CLEAR_ROW: mem[mem_row] <= '0;
                                clock_pkg::FB_SET_PIXEL: mem[mem_row][mem_col] <= 1'b1;
                                default: ;
                        endcase
                end
        end

        // registered row read, one cycle latency
        always_ff @(posedge clk) begin
                if (mem_op == clock_pkg::FB_READ_ROW)
                        mem_rdata <= mem[mem_row];
        end

endmodule

`default_nettype wire

// File: logic/hand_plotter.sv
`default_nettype none

`include "clock_defs.svh"

module hand_plotter (
        input  logic                   clk,
        input  logic                   reset,
        input  logic                   slow_clk,
        input  logic [3:0]             hour,
        input  logic [5:0]             minute,
        input  logic [5:0]             second,
        input  logic [3:0]             al_hour,
        input  logic [5:0]             al_minute,
        output logic                   plot_req,
        output clock_pkg::fb_op_e      plot_op,
        output logic [`FB_ADDR_W-1:0]  plot_row,
        output logic [`FB_ADDR_W-1:0]  plot_col,
        input  logic                   plot_gnt,
        output logic                   frame_busy
);

        clock_pkg::draw_state_e state;
        clock_pkg::draw_state_e next_state;

        logic                        inhibit;
        logic                        start;
        logic                        last;
        // clear row in CLEAR, radius while drawing
        logic [5:0]                  cnt;
        logic [9:0]                  hour_mins;
        logic [`ANGLE_W-1:0]         hour_ang;
        logic [`ANGLE_W-1:0]         min_ang;
        logic [`ANGLE_W-1:0]         sec_ang;
        logic [`ANGLE_W-1:0]         alarm_ang;
        logic [`ANGLE_W-1:0]         cur_angle;
        logic [4:0]                  hand_len;
        logic signed [`TRIG_W-1:0]   sin_val;
        logic signed [`TRIG_W-1:0]   cos_val;
        logic signed [13:0]          prod_s;
        logic signed [13:0]          prod_c;
        logic signed [13:0]          quo_s;
        logic signed [13:0]          quo_c;

        // one frame per high phase of slow_clk
        assign start      = (state == clock_pkg::IDLE) && slow_clk && !inhibit;
        assign frame_busy = (state != clock_pkg::IDLE);
        assign plot_req   = frame_busy;

        // hour hand creeps with the minutes
        assign hour_mins = 10'(hour) * 10'd60 + 10'(minute);

        // time is sampled once per frame
        always_ff @(posedge clk) begin
                if (start) begin
                        hour_ang  <= 9'(hour_mins >> 1);
                        min_ang   <= 9'(minute) * 9'd6;
                        sec_ang   <= 9'(second) * 9'd6;
                        // alarm moves in 10 minute steps
                        alarm_ang <= 9'(al_hour) * 9'd30 + 9'(al_minute / 6'd10) * 9'd6;
                end
        end

        // per-state hand, length and command
        always_comb begin
                cur_angle  = hour_ang;
                hand_len   = 5'(`HOUR_LEN);
                next_state = clock_pkg::DRAW_MIN;
                plot_op    = clock_pkg::FB_SET_PIXEL;
                case (state)
                        clock_pkg::IDLE: begin
                                plot_op = clock_pkg::FB_NOP;
                        end
                        clock_pkg::CLEAR: begin
                                plot_op    = clock_pkg::FB_CLEAR_ROW;
                                next_state = clock_pkg::DRAW_HOUR;
                        end
                        clock_pkg::DRAW_MIN: begin
                                cur_angle  = min_ang;
                                hand_len   = 5'(`MIN_LEN);
                                next_state = clock_pkg::DRAW_SEC;
                        end
                        clock_pkg::DRAW_SEC: begin
                                cur_angle  = sec_ang;
                                hand_len   = 5'(`SEC_LEN);
                                next_state = clock_pkg::DRAW_ALARM;
                        end
                        clock_pkg::DRAW_ALARM: begin
                                cur_angle  = alarm_ang;
                                hand_len   = 5'(`ALARM_LEN);
                                next_state = clock_pkg::IDLE;
                        end
                        default: ;
                endcase
        end

        sin_cos_lut u_lut (
                .angle   (cur_angle),
                .sin_val (sin_val),
                .cos_val (cos_val)
        );

        // offset = trig * r / 127, truncated toward zero
        assign prod_s = sin_val * $signed({1'b0, cnt[4:0]});
        assign prod_c = cos_val * $signed({1'b0, cnt[4:0]});
        assign quo_s  = prod_s / 14'(`TRIG_MAX);
        assign quo_c  = prod_c / 14'(`TRIG_MAX);

        // y grows downward, so cos is subtracted
        assign plot_row = (state == clock_pkg::CLEAR) ? cnt :
                          6'(`FB_CENTER - 1 - quo_c);
        assign plot_col = (state == clock_pkg::CLEAR) ? 6'd0 :
                          6'(`FB_CENTER + quo_s);

        assign last = (state == clock_pkg::CLEAR) ? (cnt == 6'd63) : (cnt[4:0] == hand_len);

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        state   <= clock_pkg::IDLE;
                        cnt     <= 6'd0;
                        inhibit <= 1'b0;
                end else begin
                        // rearm only once slow_clk has dropped
                        if (!slow_clk)
                                inhibit <= 1'b0;
                        else if (start)
                                inhibit <= 1'b1;

                        if (state == clock_pkg::IDLE) begin
                                if (start) begin
                                        state <= clock_pkg::CLEAR;
                                        cnt   <= 6'd0;
                                end
                        end else if (plot_gnt) begin
                                // odd radii only, restart at 1 per hand
                                if (last) begin
                                        state <= next_state;
                                        cnt   <= 6'd1;
                                end else begin
                                        cnt <= cnt + ((state == clock_pkg::CLEAR) ? 6'd1 : 6'd2);
                                end
                        end
                end
        end

endmodule

`default_nettype wire

// File: logic/pixel_scanner.sv
`default_nettype none

`include "clock_defs.svh"

module pixel_scanner (
        input  logic                   clk,
        input  logic                   reset,
        input  logic [`COORD_W-1:0]    horiz_count,
        input  logic [`COORD_W-1:0]    vert_count,
        input  logic [`COORD_W-1:0]    x_offset,
        input  logic [`COORD_W-1:0]    y_offset,
        output logic                   scan_req,
        output logic [`FB_ADDR_W-1:0]  scan_row,
        input  logic [`FB_DIM-1:0]     mem_rdata,
        output logic                   pixel_bw
);

        logic [`COORD_W-1:0]   h_adj;
        logic [`COORD_W-1:0]   v_adj;
        logic                  in_win;
        logic [`FB_ADDR_W-1:0] col_q;
        logic                  win_q;

        // wraps below the offset, which lands outside the window
        assign h_adj = horiz_count - x_offset;
        assign v_adj = vert_count - y_offset;

        // 448 x 448 screen area
        assign in_win = (h_adj < 10'(`FB_DIM * `SCALE)) && (v_adj < 10'(`FB_DIM * `SCALE));

        // row fetch only inside the window
        assign scan_req = in_win;
        assign scan_row = 6'(v_adj / 10'(`SCALE));

        // column travels alongside the row read
        always_ff @(posedge clk) begin
                col_q <= 6'(h_adj / 10'(`SCALE));
        end

        always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                        win_q    <= 1'b0;
                        pixel_bw <= 1'b0;
                end else begin
                        win_q    <= in_win;
                        // second stage, bit pick from the fetched row
                        pixel_bw <= win_q & mem_rdata[col_q];
                end
        end

endmodule

`default_nettype wire

// File: logic/sin_cos_lut.sv
`default_nettype none

`include "clock_defs.svh"

module sin_cos_lut (
        input  logic [`ANGLE_W-1:0]        angle,
        output logic signed [`TRIG_W-1:0]  sin_val,
        output logic signed [`TRIG_W-1:0]  cos_val
);

        // round(127 * sin d), d = 0..90
        // cos d is read back as entry 90 - d
        localparam logic signed [`TRIG_W-1:0] SIN_TBL [0:90] = '{
                8'sd0,   8'sd2,   8'sd4,   8'sd7,   8'sd9,   8'sd11,  8'sd13,  8'sd15,
                8'sd18,  8'sd20,  8'sd22,  8'sd24,  8'sd26,  8'sd29,  8'sd31,  8'sd33,
                8'sd35,  8'sd37,  8'sd39,  8'sd41,  8'sd43,  8'sd46,  8'sd48,  8'sd50,
                8'sd52,  8'sd54,  8'sd56,  8'sd58,  8'sd60,  8'sd62,  8'sd64,  8'sd65,
                8'sd67,  8'sd69,  8'sd71,  8'sd73,  8'sd75,  8'sd76,  8'sd78,  8'sd80,
                8'sd82,  8'sd83,  8'sd85,  8'sd87,  8'sd88,  8'sd90,  8'sd91,  8'sd93,
                8'sd94,  8'sd96,  8'sd97,  8'sd99,  8'sd100, 8'sd101, 8'sd103, 8'sd104,
                8'sd105, 8'sd107, 8'sd108, 8'sd109, 8'sd110, 8'sd111, 8'sd112, 8'sd113,
                8'sd114, 8'sd115, 8'sd116, 8'sd117, 8'sd118, 8'sd119, 8'sd119, 8'sd120,
                8'sd121, 8'sd121, 8'sd122, 8'sd123, 8'sd123, 8'sd124, 8'sd124, 8'sd125,
                8'sd125, 8'sd125, 8'sd126, 8'sd126, 8'sd126, 8'sd127, 8'sd127, 8'sd127,
                8'sd127, 8'sd127, 8'sd127
        };

        logic [`ANGLE_W-1:0] wrapped;
        logic [1:0]          quad;
        logic [6:0]          idx;
        logic [6:0]          idx_mir;

        // out of range angles wrap once, max input is 511
        assign wrapped = (angle >= 9'd360) ? angle - 9'd360 : angle;
        assign idx_mir = 7'd90 - idx;

        // quadrant and offset inside it
        always_comb begin
                if (wrapped >= 9'd270) begin
                        quad = 2'd3;
                        idx  = 7'(wrapped - 9'd270);
                end else if (wrapped >= 9'd180) begin
                        quad = 2'd2;
                        idx  = 7'(wrapped - 9'd180);
                end else if (wrapped >= 9'd90) begin
                        quad = 2'd1;
                        idx  = 7'(wrapped - 9'd90);
                end else begin
                        quad = 2'd0;
                        idx  = 7'(wrapped);
                end
        end

        // fold back onto the first quadrant
        always_comb begin
                case (quad)
                        2'd1: begin
                                sin_val = SIN_TBL[idx_mir];
                                cos_val = -SIN_TBL[idx];
                        end
                        2'd2: begin
                                sin_val = -SIN_TBL[idx];
                                cos_val = -SIN_TBL[idx_mir];
                        end
                        2'd3: begin
                                sin_val = -SIN_TBL[idx_mir];
                                cos_val = SIN_TBL[idx];
                        end
                        default: begin
                                sin_val = SIN_TBL[idx];
                                cos_val = SIN_TBL[idx_mir];
                        end
                endcase
        end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the clock renderer testbench; exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
        -f sources.f \
        --top-module clock_renderer_tb \
        -o clock_renderer_sim

./obj_dir/clock_renderer_sim

// File: sources.f
+incdir+logic
logic/clock_pkg.sv
logic/sin_cos_lut.sv
logic/hand_plotter.sv
logic/framebuffer_arbiter.sv
logic/framebuffer_ram.sv
logic/pixel_scanner.sv
logic/clock_renderer.sv
dv/clock_renderer_props.sv
dv/clock_renderer_tb.sv
